// ==== all.f ====
src/dual_pipe_pkg.sv
src/issue_stage.sv
src/alu.sv
src/branch_resolve.sv
src/pipe_regs.sv
src/regfile.sv
src/dual_issue_backend.sv
sim/tb_backend.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build tb_backend with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_backend
	@out="$$(./obj_dir/Vtb_backend)"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== sim/tb_backend.sv ====
`timescale 1ns/1ps

module tb_backend;

    localparam int XLEN = 32;
    localparam int SHW  = $clog2(XLEN);

    localparam int M_BUBBLE  = 0;
    localparam int M_ALU     = 1;
    localparam int M_MISPRED = 2;
    localparam int M_CORRECT = 3;
    localparam int M_SAME_RD = 4;
    localparam int M_MIXED   = 5;
    localparam int M_INVALID = 6;

    typedef logic [XLEN-1:0]                  word_t;
    typedef logic [dual_pipe_pkg::REG_AW-1:0] raddr_t;

    logic                    clk, rstn, stall;
    logic                    valid_a, valid_b, we_a, we_b, pred_taken_a;
    dual_pipe_pkg::alu_op_t  op_a, op_b;
    dual_pipe_pkg::br_cond_t br_cond_a;
    word_t                   src1_a, src2_a, src1_b, src2_b, pc_a, imm_a;
    raddr_t                  rd_a, rd_b, raddr0, raddr1;
    logic                    redirect;
    word_t                   redirect_pc, rdata0, rdata1;

    word_t model_regs [dual_pipe_pkg::NUM_REGS];
    logic  flag_q [$];                  // Expected redirect per captured pair
    word_t pc_q [$];
    string test_name;
    logic  read_check;
    int    reg_errors, redirect_errors;

    dual_issue_backend #(.XLEN(XLEN)) i_dut (.*);

    always #20 clk = ~clk;

    function automatic word_t rand_word();
        return word_t'({$urandom(), $urandom()});
    endfunction

    function automatic word_t alu_model(dual_pipe_pkg::alu_op_t op, word_t a, word_t b);
        case (op)
            dual_pipe_pkg::ALU_ADD: return a + b;
            dual_pipe_pkg::ALU_SUB: return a - b;
            dual_pipe_pkg::ALU_AND: return a & b;
            dual_pipe_pkg::ALU_OR:  return a | b;
            dual_pipe_pkg::ALU_XOR: return a ^ b;
            dual_pipe_pkg::ALU_SLL: return a << b[SHW-1:0];
            dual_pipe_pkg::ALU_SRL: return a >> b[SHW-1:0];
            default:                return word_t'($signed(a) < $signed(b));
        endcase
    endfunction

    function automatic logic branch_taken(dual_pipe_pkg::br_cond_t c, word_t a, word_t b);
        case (c)
            dual_pipe_pkg::BR_EQ: return a == b;
            dual_pipe_pkg::BR_NE: return a != b;
            dual_pipe_pkg::BR_LT: return $signed(a) < $signed(b);
            default:              return 1'b0;
        endcase
    endfunction

    task automatic check_reg(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            reg_errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_redirect(input string name, input logic exp_flag, input word_t exp_pc,
                                  input logic act_flag, input word_t act_pc);
        if (act_flag !== exp_flag || (exp_flag && act_pc !== exp_pc))
        begin
            redirect_errors++;
            $display("MISMATCH %s redirect expected %b pc %h actual %b pc %h",
                     name, exp_flag, exp_pc, act_flag, act_pc);
        end
    endtask

    // Drives one pair straight onto the DUT inputs
    task automatic gen_pair(input int mode);
        logic branch_mode;
        branch_mode  = (mode == M_MISPRED || mode == M_CORRECT ||
                        mode == M_MIXED || mode == M_INVALID);
        valid_a      = (mode != M_BUBBLE);
        valid_b      = (mode != M_BUBBLE);
        we_a         = (mode != M_BUBBLE);
        we_b         = (mode != M_BUBBLE);
        op_a         = dual_pipe_pkg::alu_op_t'(3'($urandom_range(0, 7)));
        op_b         = dual_pipe_pkg::alu_op_t'(3'($urandom_range(0, 7)));
        src1_a       = rand_word();
        src2_a       = rand_word();
        src1_b       = rand_word();
        src2_b       = rand_word();
        rd_a         = raddr_t'($urandom_range(0, 31));
        rd_b         = raddr_t'($urandom_range(0, 31));
        br_cond_a    = dual_pipe_pkg::BR_NONE;
        pred_taken_a = 1'($urandom_range(0, 1));
        pc_a         = rand_word() & ~word_t'(3);
        imm_a        = rand_word() & ~word_t'(3);
        if (mode == M_SAME_RD)
        begin
            rd_a = raddr_t'($urandom_range(0, 3));      // x0 comes up often
            rd_b = rd_a;
        end
        if (branch_mode)
        begin
            br_cond_a = dual_pipe_pkg::br_cond_t'(2'($urandom_range(
                            (mode == M_MISPRED || mode == M_CORRECT) ? 1 : 0, 3)));
            if ($urandom_range(0, 1) == 1)
                src2_a = src1_a;                        // Equal operands half the time
            if (mode == M_MISPRED)
                pred_taken_a = ~branch_taken(br_cond_a, src1_a, src2_a);
            if (mode == M_CORRECT)
                pred_taken_a = branch_taken(br_cond_a, src1_a, src2_a);
        end
        if (mode == M_INVALID)
        begin
            valid_a = 1'($urandom_range(0, 1));
            valid_b = valid_a ? 1'b0 : 1'($urandom_range(0, 1));
        end
    endtask

    // Pair in program order, A then B
    task automatic apply_model();
        logic  taken;
        logic  mis;
        word_t target;
        mis    = 1'b0;
        target = '0;
        if (valid_a && br_cond_a != dual_pipe_pkg::BR_NONE)
        begin
            taken  = branch_taken(br_cond_a, src1_a, src2_a);
            mis    = (taken != pred_taken_a);
            target = taken ? pc_a + imm_a : pc_a + word_t'(4);
        end
        if (valid_a && we_a && rd_a != '0)
            model_regs[rd_a] = alu_model(op_a, src1_a, src2_a);
        if (!mis && valid_b && we_b && rd_b != '0)
            model_regs[rd_b] = alu_model(op_b, src1_b, src2_b);
        flag_q.push_back(mis);
        pc_q.push_back(target);
    endtask

    task automatic step(input logic st, input int mode);
        logic  exp_flag;
        word_t exp_pc;
        @(negedge clk);
        if (read_check)
        begin
            check_reg($sformatf("%s x%0d port0", test_name, raddr0), model_regs[raddr0], rdata0);
            check_reg($sformatf("%s x%0d port1", test_name, raddr1), model_regs[raddr1], rdata1);
        end
        exp_flag = 1'b0;                                // Always low while stalled
        exp_pc   = '0;
        if (!stall && flag_q.size() > 0)
        begin
            exp_flag = flag_q.pop_front();
            exp_pc   = pc_q.pop_front();
        end
        check_redirect(test_name, exp_flag, exp_pc, redirect, redirect_pc);
        stall = st;
        gen_pair(mode);
        if (!st)
            apply_model();
    endtask

    task automatic drain();
        for (int idle = 0; idle < 4; idle++)
            step(1'b0, M_BUBBLE);
    endtask

    task automatic read_all();
        for (int k = 0; k <= 32; k++)
        begin
            read_check = (k > 0);
            step(1'b0, M_BUBBLE);
            raddr0 = raddr_t'(k % 32);
            raddr1 = raddr_t'(31 - (k % 32));
        end
        read_check = 1'b0;
    endtask

    task automatic run_pairs(input string name, input int mode, input int count,
                             input logic with_stall);
        test_name = name;
        for (int n = 0; n < count; n++)
            step(with_stall ? 1'($urandom_range(0, 2) == 0) : 1'b0, mode);
        drain();
        read_all();
    endtask

    initial
    begin
        int cycles;
        void'($urandom(32'h7407));
        clk        = 1'b0;
        rstn       = 1'b0;
        stall      = 1'b0;
        raddr0     = '0;
        raddr1     = '0;
        read_check = 1'b0;
        gen_pair(M_BUBBLE);
        for (int i = 0; i < dual_pipe_pkg::NUM_REGS; i++)
            model_regs[i] = '0;
        cycles = 0;
        while (cycles < 4)
        begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
        rstn      = 1'b1;
        test_name = "reset";
        read_all();

        run_pairs("alu_random", M_ALU, 40, 1'b0);
        run_pairs("mispredict", M_MISPRED, 30, 1'b0);
        run_pairs("correct_predict", M_CORRECT, 30, 1'b0);
        run_pairs("same_rd", M_SAME_RD, 30, 1'b0);
        run_pairs("stall_mixed", M_MIXED, 80, 1'b1);
        run_pairs("invalid_slots", M_INVALID, 40, 1'b0);

        $display("errors: reg=%0d redirect=%0d", reg_errors, redirect_errors);
        if (reg_errors + redirect_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== src/dual_issue_backend.sv ====
`timescale 1ns/1ps

module dual_issue_backend #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              stall,

    input  logic                              valid_a,
    input  logic                              valid_b,
    input  dual_pipe_pkg::alu_op_t            op_a,
    input  dual_pipe_pkg::alu_op_t            op_b,
    input  logic [XLEN-1:0]                   src1_a,
    input  logic [XLEN-1:0]                   src2_a,
    input  logic [XLEN-1:0]                   src1_b,
    input  logic [XLEN-1:0]                   src2_b,
    input  logic [dual_pipe_pkg::REG_AW-1:0]  rd_a,
    input  logic [dual_pipe_pkg::REG_AW-1:0]  rd_b,
    input  logic                              we_a,
    input  logic                              we_b,
    input  dual_pipe_pkg::br_cond_t           br_cond_a,
    input  logic                              pred_taken_a,
    input  logic [XLEN-1:0]                   pc_a,
    input  logic [XLEN-1:0]                   imm_a,

    output logic                              redirect,
    output logic [XLEN-1:0]                   redirect_pc,

    input  logic [dual_pipe_pkg::REG_AW-1:0]  raddr0,
    input  logic [dual_pipe_pkg::REG_AW-1:0]  raddr1,
    output logic [XLEN-1:0]                   rdata0,
    output logic [XLEN-1:0]                   rdata1
);

    dual_pipe_pkg::alu_op_t            ex_op_a, ex_op_b;
    dual_pipe_pkg::br_cond_t           ex_br_cond_a;
    logic [XLEN-1:0]                   ex_src1_a, ex_src2_a, ex_src1_b, ex_src2_b;
    logic [XLEN-1:0]                   ex_pc_a, ex_imm_a;
    logic [dual_pipe_pkg::REG_AW-1:0]  ex_rd_a, ex_rd_b;
    logic                              ex_we_a, ex_we_b, ex_pred_taken_a;
    logic [XLEN-1:0]                   ex_result_a, ex_result_b;
    logic                              br_a;
    logic [XLEN-1:0]                   wb_result_a, wb_result_b;
    logic                              wb_we_a, wb_we_b;
    logic [dual_pipe_pkg::REG_AW-1:0]  wb_rd_a, wb_rd_b;

    issue_stage #(.XLEN(XLEN)) i_issue (
        .clk, .rstn, .stall,
        .valid_a, .valid_b, .op_a, .op_b, .src1_a, .src2_a, .src1_b, .src2_b,
        .rd_a, .rd_b, .we_a, .we_b, .br_cond_a, .pred_taken_a, .pc_a, .imm_a,
        .ex_op_a, .ex_op_b, .ex_src1_a, .ex_src2_a, .ex_src1_b, .ex_src2_b,
        .ex_rd_a, .ex_rd_b, .ex_we_a, .ex_we_b, .ex_br_cond_a, .ex_pred_taken_a,
        .ex_pc_a, .ex_imm_a
    );

    alu #(.XLEN(XLEN)) i_alu_a (
        .op(ex_op_a), .src1(ex_src1_a), .src2(ex_src2_a), .result(ex_result_a)
    );

    alu #(.XLEN(XLEN)) i_alu_b (
        .op(ex_op_b), .src1(ex_src1_b), .src2(ex_src2_b), .result(ex_result_b)
    );

    branch_resolve #(.XLEN(XLEN)) i_branch (
        .br_cond(ex_br_cond_a), .pred_taken(ex_pred_taken_a),
        .src1(ex_src1_a), .src2(ex_src2_a), .pc(ex_pc_a), .imm(ex_imm_a),
        .br_a, .redirect_pc
    );

    assign redirect = br_a & ~stall;    // Pair is held in EX while stalled

    pipe_regs #(.XLEN(XLEN)) i_pipe (
        .clk, .rstn, .stall, .br_a,
        .ex_result_a, .ex_result_b, .ex_we_a, .ex_we_b, .ex_rd_a, .ex_rd_b,
        .mem_result_a(), .mem_result_b(), .mem_we_a(), .mem_we_b(),
        .mem_rd_a(), .mem_rd_b(),
        .wb_result_a, .wb_result_b, .wb_we_a, .wb_we_b, .wb_rd_a, .wb_rd_b
    );

    regfile #(.XLEN(XLEN)) i_regfile (
        .clk, .rstn,
        .we_a(wb_we_a), .we_b(wb_we_b), .waddr_a(wb_rd_a), .waddr_b(wb_rd_b),
        .wdata_a(wb_result_a), .wdata_b(wb_result_b),
        .raddr0, .raddr1, .rdata0, .rdata1
    );

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rstn,

    input  logic                              we_a,
    input  logic                              we_b,
    input  logic [dual_pipe_pkg::REG_AW-1:0]  waddr_a,
    input  logic [dual_pipe_pkg::REG_AW-1:0]  waddr_b,
    input  logic [XLEN-1:0]                   wdata_a,
    input  logic [XLEN-1:0]                   wdata_b,

    input  logic [dual_pipe_pkg::REG_AW-1:0]  raddr0,
    input  logic [dual_pipe_pkg::REG_AW-1:0]  raddr1,
    output logic [XLEN-1:0]                   rdata0,
    output logic [XLEN-1:0]                   rdata1
);

    logic [XLEN-1:0] regs [dual_pipe_pkg::NUM_REGS];

    logic wr_a;
    logic wr_b;

    // x0 is never written
    assign wr_a = we_a && (waddr_a != '0);
    assign wr_b = we_b && (waddr_b != '0);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < dual_pipe_pkg::NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            if (wr_a)
            begin
                regs[waddr_a] <= wdata_a;
            end
            if (wr_b)
            begin
                regs[waddr_b] <= wdata_b;   // Later write wins on same address
            end
        end
    end

    always_comb
    begin
        if (raddr0 == '0)
        begin
            rdata0 = '0;
        end
        else
        begin
            rdata0 = regs[raddr0];
        end
        if (raddr1 == '0)
        begin
            rdata1 = '0;
        end
        else
        begin
            rdata1 = regs[raddr1];
        end
    end

endmodule

// ==== src/pipe_regs.sv ====
`timescale 1ns/1ps

module pipe_regs #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              stall,

    input  logic                              br_a,          // Slot A mispredict in EX
    input  logic [XLEN-1:0]                   ex_result_a,
    input  logic [XLEN-1:0]                   ex_result_b,
    input  logic                              ex_we_a,
    input  logic                              ex_we_b,
    input  logic [dual_pipe_pkg::REG_AW-1:0]  ex_rd_a,
    input  logic [dual_pipe_pkg::REG_AW-1:0]  ex_rd_b,

    output logic [XLEN-1:0]                   mem_result_a,
    output logic [XLEN-1:0]                   mem_result_b,
    output logic                              mem_we_a,
    output logic                              mem_we_b,
    output logic [dual_pipe_pkg::REG_AW-1:0]  mem_rd_a,
    output logic [dual_pipe_pkg::REG_AW-1:0]  mem_rd_b,

    output logic [XLEN-1:0]                   wb_result_a,
    output logic [XLEN-1:0]                   wb_result_b,
    output logic                              wb_we_a,
    output logic                              wb_we_b,
    output logic [dual_pipe_pkg::REG_AW-1:0]  wb_rd_a,
    output logic [dual_pipe_pkg::REG_AW-1:0]  wb_rd_b
);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            mem_we_a <= 1'b0;
            mem_we_b <= 1'b0;
            wb_we_a  <= 1'b0;
            wb_we_b  <= 1'b0;
        end
        else if (!stall)
        begin
            mem_we_a <= ex_we_a;
            mem_we_b <= ex_we_b & ~br_a;    // Younger slot squashed
            wb_we_a  <= mem_we_a;
            wb_we_b  <= mem_we_b;
        end
    end

    // No load or store in MEM so results pass straight through
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            mem_result_a <= ex_result_a;
            mem_rd_a     <= ex_rd_a;
            mem_rd_b     <= ex_rd_b;
            if (br_a)
            begin
                mem_result_b <= '0;
            end
            else
            begin
                mem_result_b <= ex_result_b;
            end

            wb_result_a <= mem_result_a;
            wb_result_b <= mem_result_b;
            wb_rd_a     <= mem_rd_a;
            wb_rd_b     <= mem_rd_b;
        end
    end

endmodule

// ==== src/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve #(
    parameter int XLEN = 32
) (
    input  dual_pipe_pkg::br_cond_t  br_cond,
    input  logic                     pred_taken,
    input  logic [XLEN-1:0]          src1,
    input  logic [XLEN-1:0]          src2,
    input  logic [XLEN-1:0]          pc,
    input  logic [XLEN-1:0]          imm,
    output logic                     br_a,
    output logic [XLEN-1:0]          redirect_pc
);

    logic is_branch;
    logic taken;

    assign is_branch = (br_cond != dual_pipe_pkg::BR_NONE);

    always_comb
    begin
        case (br_cond)
            dual_pipe_pkg::BR_EQ:
            begin
                taken = (src1 == src2);
            end
            dual_pipe_pkg::BR_NE:
            begin
                taken = (src1 != src2);
            end
            dual_pipe_pkg::BR_LT:
            begin
                taken = $signed(src1) < $signed(src2);
            end
            default:
            begin
                taken = 1'b0;
            end
        endcase
    end

    // Prediction bit is ignored for non-branches
    assign br_a = is_branch & (taken != pred_taken);

    assign redirect_pc = taken ? pc + imm : pc + XLEN'(4);   // Fall-through on not taken

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu #(
    parameter int XLEN = 32
) (
    input  dual_pipe_pkg::alu_op_t  op,
    input  logic [XLEN-1:0]         src1,
    input  logic [XLEN-1:0]         src2,
    output logic [XLEN-1:0]         result
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;
    logic           lt;

    assign shamt = src2[SHW-1:0];                  // Low bits only
    assign lt    = $signed(src1) < $signed(src2);

    always_comb
    begin
        case (op)
            dual_pipe_pkg::ALU_ADD:
            begin
                result = src1 + src2;
            end
            dual_pipe_pkg::ALU_SUB:
            begin
                result = src1 - src2;
            end
            dual_pipe_pkg::ALU_AND:
            begin
                result = src1 & src2;
            end
            dual_pipe_pkg::ALU_OR:
            begin
                result = src1 | src2;
            end
            dual_pipe_pkg::ALU_XOR:
            begin
                result = src1 ^ src2;
            end
            dual_pipe_pkg::ALU_SLL:
            begin
                result = src1 << shamt;
            end
            dual_pipe_pkg::ALU_SRL:
            begin
                result = src1 >> shamt;                 // Logical
            end
            dual_pipe_pkg::ALU_SLT:
            begin
                result = {{(XLEN-1){1'b0}}, lt};
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== src/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              stall,

    input  logic                              valid_a,
    input  logic                              valid_b,
    input  dual_pipe_pkg::alu_op_t            op_a,
    input  dual_pipe_pkg::alu_op_t            op_b,
    input  logic [XLEN-1:0]                   src1_a,
    input  logic [XLEN-1:0]                   src2_a,
    input  logic [XLEN-1:0]                   src1_b,
    input  logic [XLEN-1:0]                   src2_b,
    input  logic [dual_pipe_pkg::REG_AW-1:0]  rd_a,
    input  logic [dual_pipe_pkg::REG_AW-1:0]  rd_b,
    input  logic                              we_a,
    input  logic                              we_b,
    input  dual_pipe_pkg::br_cond_t           br_cond_a,
    input  logic                              pred_taken_a,
    input  logic [XLEN-1:0]                   pc_a,
    input  logic [XLEN-1:0]                   imm_a,

    output dual_pipe_pkg::alu_op_t            ex_op_a,
    output dual_pipe_pkg::alu_op_t            ex_op_b,
    output logic [XLEN-1:0]                   ex_src1_a,
    output logic [XLEN-1:0]                   ex_src2_a,
    output logic [XLEN-1:0]                   ex_src1_b,
    output logic [XLEN-1:0]                   ex_src2_b,
    output logic [dual_pipe_pkg::REG_AW-1:0]  ex_rd_a,
    output logic [dual_pipe_pkg::REG_AW-1:0]  ex_rd_b,
    output logic                              ex_we_a,
    output logic                              ex_we_b,
    output dual_pipe_pkg::br_cond_t           ex_br_cond_a,
    output logic                              ex_pred_taken_a,
    output logic [XLEN-1:0]                   ex_pc_a,
    output logic [XLEN-1:0]                   ex_imm_a
);

    // Invalid slot becomes a bubble
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            ex_we_a      <= 1'b0;
            ex_we_b      <= 1'b0;
            ex_br_cond_a <= dual_pipe_pkg::BR_NONE;
        end
        else if (!stall)
        begin
            ex_we_a      <= valid_a & we_a;
            ex_we_b      <= valid_b & we_b;
            ex_br_cond_a <= valid_a ? br_cond_a : dual_pipe_pkg::BR_NONE;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            ex_op_a         <= op_a;
            ex_op_b         <= op_b;
            ex_src1_a       <= src1_a;
            ex_src2_a       <= src2_a;
            ex_src1_b       <= src1_b;
            ex_src2_b       <= src2_b;
            ex_rd_a         <= rd_a;
            ex_rd_b         <= rd_b;
            ex_pred_taken_a <= pred_taken_a;
            ex_pc_a         <= pc_a;
            ex_imm_a        <= imm_a;
        end
    end

endmodule

// ==== src/dual_pipe_pkg.sv ====
package dual_pipe_pkg;

    // Register file geometry
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    localparam int ALU_OP_W  = 3;
    localparam int BR_COND_W = 2;

    // ALU operation of one slot
    typedef enum logic [ALU_OP_W-1:0]
    {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7    // Signed compare
    } alu_op_t;

    // Branch condition of slot A
    typedef enum logic [BR_COND_W-1:0]
    {
        BR_NONE = 2'd0,   // Not a branch
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2,
        BR_LT   = 2'd3    // Signed
    } br_cond_t;

endpackage
